//--- datapath.f
design/datapathPkg.sv
design/registerFile.sv
design/busMux.sv
design/aluStage.sv
design/memoryPort.sv
design/fetchRegisters.sv
design/dataPath.sv
test/clockGen.sv
test/dataPathTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -Wall -Wno-fatal \
		--top-module dataPathTb -Mdir obj_dir -f datapath.f

run: compile
	./obj_dir/VdataPathTb > sim.log 2>&1 || true
	cat sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/dataPathTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataPathTb;

        import datapathPkg::*;

        localparam int Width = 32;
        localparam int Trials = 400;
        localparam int CycleLimit = Trials * 8 + 100;

        // Destination bits of one micro-operation
        localparam int toHi = 0, toLo = 1, toY = 2, toZ = 3, toPc = 4;
        localparam int doInc = 5, toIr = 6, toMar = 7, toMdr = 8, doRead = 9;
        localparam int NoSource = -1;

        logic Clock, arstN;
        logic [RegCount-1:0] regIn, regOut;
        logic hiIn, loIn, hiOut, loOut, zIn, zHighOut, zLowOut, yIn;
        logic pcIn, pcOut, incPc, irIn, marIn, mdrIn, mdrOut, read;
        aluOp_t opcode;
        logic [Width-1:0] mDataIn, busData, marAddress, irWord;

        logic [Width-1:0] modelReg [RegCount];
        logic [Width-1:0] modelHi, modelLo, modelY, modelZHigh, modelZLow;
        logic [Width-1:0] modelPc, modelIr, modelMar, modelMdr;
        int cycleCount = 0;
        aluOp_t opList [12] = '{Add, Sub, And, Or, Shr, Shl, Ror, Rol, Mul, Div, Neg, Not};

        clockGen clockGen_i (.Clock(Clock), .arstN(arstN));

        dataPath #(.DataWidth(Width)) dut_i (
                .Clock(Clock), .arstN(arstN), .regIn(regIn), .regOut(regOut),
                .hiIn(hiIn), .loIn(loIn), .hiOut(hiOut), .loOut(loOut), .zIn(zIn),
                .zHighOut(zHighOut), .zLowOut(zLowOut), .yIn(yIn), .pcIn(pcIn),
                .pcOut(pcOut), .incPc(incPc), .irIn(irIn), .marIn(marIn),
                .mdrIn(mdrIn), .mdrOut(mdrOut), .read(read), .opcode(opcode),
                .mDataIn(mDataIn), .busData(busData), .marAddress(marAddress),
                .irWord(irWord)
        );

        task automatic reportError(string what, logic [Width-1:0] got, logic [Width-1:0] exp);
                $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
                $display("*** FAILED ***");
                $fatal(1);
        endtask

        function automatic logic [Width-1:0] sourceValue(int src);
                if (src >= 0 && src < RegCount) return modelReg[src];
                case (src)
                        16: return modelHi;
                        17: return modelLo;
                        18: return modelZHigh;
                        19: return modelZLow;
                        20: return modelPc;
                        21: return modelMdr;
                        default: return '0;
                endcase
        endfunction

        // Result as {high, low} for Y op b
        function automatic logic [2*Width-1:0] aluModel(aluOp_t op, logic [Width-1:0] y,
                                                        logic [Width-1:0] b);
                int s;
                s = b[4:0];
                case (op)
                        Add: return {32'd0, y + b};
                        Sub: return {32'd0, y - b};
                        And: return {32'd0, y & b};
                        Or:  return {32'd0, y | b};
                        Shr: return {32'd0, y >> s};
                        Shl: return {32'd0, y << s};
                        Ror: return {32'd0, (s == 0) ? y : ((y >> s) | (y << (32 - s)))};
                        Rol: return {32'd0, (s == 0) ? y : ((y << s) | (y >> (32 - s)))};
                        Mul: return 64'($signed(y)) * 64'($signed(b));
                        Div: begin
                                if (b == 0) return {y, 32'hffff_ffff};
                                return {32'($signed(y) % $signed(b)),
                                        32'($signed(y) / $signed(b))};
                        end
                        Neg: return {32'd0, -b};
                        Not: return {32'd0, ~b};
                        default: return '0;
                endcase
        endfunction

        // One cycle drives the strobes, checks the bus and outputs and then advances the model
        task automatic microOp(int src, logic [RegCount-1:0] regMask, logic [9:0] dst,
                               aluOp_t op, logic [Width-1:0] mem);
                logic [Width-1:0] expBus;
                logic [2*Width-1:0] result;
                @(posedge Clock);
                regOut <= (src >= 0 && src < RegCount) ? RegCount'(1) << src : '0;
                hiOut <= (src == 16);
                loOut <= (src == 17);
                zHighOut <= (src == 18);
                zLowOut <= (src == 19);
                pcOut <= (src == 20);
                mdrOut <= (src == 21);
                regIn <= regMask;
                hiIn <= dst[toHi];
                loIn <= dst[toLo];
                yIn <= dst[toY];
                zIn <= dst[toZ];
                pcIn <= dst[toPc];
                incPc <= dst[doInc];
                irIn <= dst[toIr];
                marIn <= dst[toMar];
                mdrIn <= dst[toMdr];
                read <= dst[doRead];
                opcode <= op;
                mDataIn <= mem;
                @(negedge Clock);
                expBus = sourceValue(src);
                assert (busData === expBus) else reportError("busData", busData, expBus);
                assert (marAddress === modelMar)
                        else reportError("marAddress", marAddress, modelMar);
                assert (irWord === modelIr) else reportError("irWord", irWord, modelIr);
                result = aluModel(op, modelY, expBus);
                for (int i = 0; i < RegCount; i++) begin
                        if (regMask[i]) modelReg[i] = expBus;
                end
                if (dst[toHi]) modelHi = expBus;
                if (dst[toLo]) modelLo = expBus;
                if (dst[toY]) modelY = expBus;
                if (dst[toZ]) {modelZHigh, modelZLow} = result;
                if (dst[toPc]) modelPc = expBus;
                else if (dst[doInc]) modelPc = modelPc + 1;
                if (dst[toIr]) modelIr = expBus;
                if (dst[toMar]) modelMar = expBus;
                if (dst[toMdr]) modelMdr = dst[doRead] ? mem : expBus;
        endtask

        // Memory word into MDR, then MDR into one register
        task automatic loadRegister(int k, logic [Width-1:0] value);
                microOp(NoSource, '0, 10'(1 << toMdr | 1 << doRead), Add, value);
                microOp(21, RegCount'(1) << k, '0, Add, '0);
        endtask

        task automatic runAluTrial(aluOp_t op, bit zeroDivisor);
                int ra, rb;
                ra = $urandom_range(0, RegCount - 1);
                rb = $urandom_range(0, RegCount - 1);
                if (zeroDivisor) begin
                        rb = (ra + 1) % RegCount;
                        loadRegister(rb, '0);
                end
                microOp(ra, '0, 10'(1 << toY), Add, '0);
                microOp(rb, '0, 10'(1 << toZ), op, '0);
                microOp(19, '0, '0, Add, '0);
                microOp(18, '0, '0, Add, '0);
        endtask

        always @(posedge Clock) begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= CycleLimit) begin
                        $display("timeout: the test did not finish within %0d cycles", CycleLimit);
                        $display("*** FAILED ***");
                        $fatal(1);
                end
        end

        initial begin
                int k, j;
                logic [Width-1:0] word;
                aluOp_t op;
                void'($urandom(32'h13617d15));
                {regIn, regOut, hiIn, loIn, hiOut, loOut, zIn, zHighOut, zLowOut} = '0;
                {yIn, pcIn, pcOut, incPc, irIn, marIn, mdrIn, mdrOut, read} = '0;
                opcode = Add;
                mDataIn = '0;
                for (int i = 0; i < RegCount; i++) modelReg[i] = '0;
                {modelHi, modelLo, modelY, modelZHigh, modelZLow} = '0;
                {modelPc, modelIr, modelMar, modelMdr} = '0;
                wait (arstN === 1'b1);
                for (int src = 0; src < SourceCount; src++) microOp(src, '0, '0, Add, '0);
                // A zero divisor gets at least one run whatever the random draws are
                runAluTrial(Div, 1'b1);
                for (int t = 0; t < Trials; t++) begin
                        case ($urandom_range(0, 3))
                                0: begin
                                        k = $urandom_range(0, RegCount - 1);
                                        j = (k + $urandom_range(1, RegCount - 1)) % RegCount;
                                        loadRegister(k, $urandom);
                                        microOp(k, '0, '0, Add, '0);
                                        microOp(j, '0, '0, Add, '0);
                                end
                                1: begin
                                        op = opList[$urandom_range(0, 11)];
                                        runAluTrial(op, op == Div && $urandom_range(0, 3) == 0);
                                end
                                2: begin
                                        microOp(NoSource, '0, 10'(1 << toMdr | 1 << doRead),
                                                Add, $urandom);
                                        microOp(21, '0, 10'(1 << toPc), Add, '0);
                                        microOp(NoSource, '0, 10'(1 << doInc), Add, '0);
                                        microOp(20, '0, 10'(1 << toMar), Add, '0);
                                        microOp(20, '0, '0, Add, '0);
                                end
                                default: begin
                                        word = $urandom;
                                        microOp(NoSource, '0, 10'(1 << toMdr | 1 << doRead),
                                                Add, word);
                                        microOp(21, '0, 10'(1 << toIr), Add, '0);
                                        microOp(18, '0, 10'(1 << toHi), Add, '0);
                                        microOp(19, '0, 10'(1 << toLo), Add, '0);
                                        microOp(16, '0, '0, Add, '0);
                                        microOp(17, '0, '0, Add, '0);
                                end
                        endcase
                end
                $display("*** PASSED ***");
                $finish;
        end

endmodule

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
        output logic Clock,
        output logic arstN
);

        initial begin
                Clock = 1'b0;
                forever #5 Clock = ~Clock;
        end

        // Reset is held for ten rising edges
        initial begin
                arstN = 1'b0;
                repeat (10) @(posedge Clock);
                arstN <= 1'b1;
        end

endmodule

`default_nettype wire

//--- design/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
        parameter int DataWidth = 32
) (
        input  wire logic                                 Clock,
        input  wire logic                                 arstN,
        input  wire logic [datapathPkg::RegCount-1:0]     regIn,
        input  wire logic [datapathPkg::RegCount-1:0]     regOut,
        input  wire logic                                 hiIn,
        input  wire logic                                 loIn,
        input  wire logic                                 hiOut,
        input  wire logic                                 loOut,
        input  wire logic                                 zIn,
        input  wire logic                                 zHighOut,
        input  wire logic                                 zLowOut,
        input  wire logic                                 yIn,
        input  wire logic                                 pcIn,
        input  wire logic                                 pcOut,
        input  wire logic                                 incPc,
        input  wire logic                                 irIn,
        input  wire logic                                 marIn,
        input  wire logic                                 mdrIn,
        input  wire logic                                 mdrOut,
        input  wire logic                                 read,
        input  wire datapathPkg::aluOp_t                  opcode,
        input  wire logic [DataWidth-1:0]                 mDataIn,
        output logic [DataWidth-1:0]                      busData,
        output logic [DataWidth-1:0]                      marAddress,
        output logic [DataWidth-1:0]                      irWord
);

        logic [datapathPkg::RegCount-1:0][DataWidth-1:0] regData;
        logic [DataWidth-1:0]                             hiData;
        logic [DataWidth-1:0]                             loData;
        logic [DataWidth-1:0]                             zHigh;
        logic [DataWidth-1:0]                             zLow;
        logic [DataWidth-1:0]                             pcData;
        logic [DataWidth-1:0]                             mdrData;

        registerFile #(.DataWidth(DataWidth)) registerFile_i (
                .Clock   (Clock),
                .arstN   (arstN),
                .bus     (busData),
                .regIn   (regIn),
                .hiIn    (hiIn),
                .loIn    (loIn),
                .regData (regData),
                .hiData  (hiData),
                .loData  (loData)
        );

        // The shared bus itself, every loadable register listens to it
        busMux #(.DataWidth(DataWidth)) busMux_i (
                .Clock    (Clock),
                .arstN    (arstN),
                .regOut   (regOut),
                .hiOut    (hiOut),
                .loOut    (loOut),
                .zHighOut (zHighOut),
                .zLowOut  (zLowOut),
                .pcOut    (pcOut),
                .mdrOut   (mdrOut),
                .regData  (regData),
                .hiData   (hiData),
                .loData   (loData),
                .zHigh    (zHigh),
                .zLow     (zLow),
                .pcData   (pcData),
                .mdrData  (mdrData),
                .bus      (busData)
        );

        aluStage #(.DataWidth(DataWidth)) aluStage_i (
                .Clock  (Clock),
                .arstN  (arstN),
                .bus    (busData),
                .yIn    (yIn),
                .zIn    (zIn),
                .opcode (opcode),
                .zHigh  (zHigh),
                .zLow   (zLow)
        );

        memoryPort #(.DataWidth(DataWidth)) memoryPort_i (
                .Clock      (Clock),
                .arstN      (arstN),
                .bus        (busData),
                .mDataIn    (mDataIn),
                .marIn      (marIn),
                .mdrIn      (mdrIn),
                .read       (read),
                .mdrData    (mdrData),
                .marAddress (marAddress)
        );

        fetchRegisters #(.DataWidth(DataWidth)) fetchRegisters_i (
                .Clock  (Clock),
                .arstN  (arstN),
                .bus    (busData),
                .pcIn   (pcIn),
                .incPc  (incPc),
                .irIn   (irIn),
                .pcData (pcData),
                .irWord (irWord)
        );

endmodule

`default_nettype wire

//--- design/fetchRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module fetchRegisters #(
        parameter int DataWidth = 32
) (
        input  wire logic                   Clock,
        input  wire logic                   arstN,
        input  wire logic [DataWidth-1:0]   bus,
        input  wire logic                   pcIn,
        input  wire logic                   incPc,
        input  wire logic                   irIn,
        output logic [DataWidth-1:0]        pcData,
        output logic [DataWidth-1:0]        irWord
);

        // A jump through the bus wins over the fetch increment
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        pcData <= '0;
                end else if (pcIn) begin
                        pcData <= bus;
                end else if (incPc) begin
                        pcData <= pcData + 1'b1;
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        irWord <= '0;
                end else if (irIn) begin
                        irWord <= bus;
                end
        end

        // The sequencer should never load and increment PC in one step
        assert property (@(posedge Clock) disable iff (!arstN) !(pcIn && incPc))
                else $error("fetchRegisters: pcIn and incPc both high");

endmodule

`default_nettype wire

//--- design/memoryPort.sv
`timescale 1ns/1ps
`default_nettype none

module memoryPort #(
        parameter int DataWidth = 32
) (
        input  wire logic                   Clock,
        input  wire logic                   arstN,
        input  wire logic [DataWidth-1:0]   bus,
        input  wire logic [DataWidth-1:0]   mDataIn,
        input  wire logic                   marIn,
        input  wire logic                   mdrIn,
        input  wire logic                   read,
        output logic [DataWidth-1:0]        mdrData,
        output logic [DataWidth-1:0]        marAddress
);

        logic [DataWidth-1:0] mdrSource;

        // Read selects the memory side, otherwise MDR takes the bus for a write
        assign mdrSource = read ? mDataIn : bus;

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        mdrData <= '0;
                end else if (mdrIn) begin
                        mdrData <= mdrSource;
                end
        end

        // MAR goes straight out as the memory address
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        marAddress <= '0;
                end else if (marIn) begin
                        marAddress <= bus;
                end
        end

endmodule

`default_nettype wire

//--- design/aluStage.sv
`timescale 1ns/1ps
`default_nettype none

module aluStage #(
        parameter int DataWidth = 32
) (
        input  wire logic                   Clock,
        input  wire logic                   arstN,
        input  wire logic [DataWidth-1:0]   bus,
        input  wire logic                   yIn,
        input  wire logic                   zIn,
        input  wire datapathPkg::aluOp_t    opcode,
        output logic [DataWidth-1:0]        zHigh,
        output logic [DataWidth-1:0]        zLow
);

        import datapathPkg::*;

        localparam int ShiftWidth = $clog2(DataWidth);

        logic [DataWidth-1:0]          yData;
        logic [ShiftWidth-1:0]         shiftAmount;
        logic [2*DataWidth-1:0]        rotateRight;
        logic [2*DataWidth-1:0]        rotateLeft;
        logic signed [2*DataWidth-1:0] product;
        logic signed [DataWidth-1:0]   quotient;
        logic signed [DataWidth-1:0]   remainder;
        logic [DataWidth-1:0]          resultHigh;
        logic [DataWidth-1:0]          resultLow;

        // Y holds the first operand, the bus supplies the second one
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        yData <= '0;
                end else if (yIn) begin
                        yData <= bus;
                end
        end

        assign shiftAmount = bus[ShiftWidth-1:0];

        // Rotating a doubled copy of Y leaves the wrapped bits in place
        assign rotateRight = {yData, yData} >> shiftAmount;
        assign rotateLeft  = {yData, yData} << shiftAmount;

        assign product = $signed(yData) * $signed(bus);

        always_comb begin
                if (bus == '0) begin
                        quotient  = '1;
                        remainder = $signed(yData);
                end else begin
                        quotient  = $signed(yData) / $signed(bus);
                        remainder = $signed(yData) % $signed(bus);
                end
        end

        always_comb begin
                resultHigh = '0;
                resultLow  = '0;
                case (opcode)
                        Add: resultLow = yData + bus;
                        Sub: resultLow = yData - bus;
                        And: resultLow = yData & bus;
                        Or:  resultLow = yData | bus;
                        Shr: resultLow = yData >> shiftAmount;
                        Shl: resultLow = yData << shiftAmount;
                        Ror: resultLow = rotateRight[DataWidth-1:0];
                        Rol: resultLow = rotateLeft[2*DataWidth-1:DataWidth];
                        Mul: begin
                                resultHigh = product[2*DataWidth-1:DataWidth];
                                resultLow  = product[DataWidth-1:0];
                        end
                        Div: begin
                                resultHigh = remainder;
                                resultLow  = quotient;
                        end
                        Neg: resultLow = -bus;
                        Not: resultLow = ~bus;
                        default: begin
                                resultHigh = '0;
                                resultLow  = '0;
                        end
                endcase
        end

        // Both halves of Z are captured together at the zIn edge
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        zHigh <= '0;
                        zLow  <= '0;
                end else if (zIn) begin
                        zHigh <= resultHigh;
                        zLow  <= resultLow;
                end
        end

        // An undefined opcode here would leave a silent zero in Z
        assert property (@(posedge Clock) disable iff (!arstN)
                zIn |-> opcode inside {Add, Sub, And, Or, Shr, Shl, Ror, Rol,
                                       Mul, Div, Neg, Not})
                else $error("aluStage: Z loaded with undefined opcode %b", opcode);

endmodule

`default_nettype wire

//--- design/busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux #(
        parameter int DataWidth = 32
) (
        input  wire logic                                 Clock,
        input  wire logic                                 arstN,
        input  wire logic [datapathPkg::RegCount-1:0]     regOut,
        input  wire logic                                 hiOut,
        input  wire logic                                 loOut,
        input  wire logic                                 zHighOut,
        input  wire logic                                 zLowOut,
        input  wire logic                                 pcOut,
        input  wire logic                                 mdrOut,
        input  wire logic [datapathPkg::RegCount-1:0][DataWidth-1:0] regData,
        input  wire logic [DataWidth-1:0]                 hiData,
        input  wire logic [DataWidth-1:0]                 loData,
        input  wire logic [DataWidth-1:0]                 zHigh,
        input  wire logic [DataWidth-1:0]                 zLow,
        input  wire logic [DataWidth-1:0]                 pcData,
        input  wire logic [DataWidth-1:0]                 mdrData,
        output logic [DataWidth-1:0]                      bus
);

        import datapathPkg::*;

        localparam int IndexWidth = $clog2(SourceCount);

        logic [SourceCount-1:0]                sourceSel;
        logic [SourceCount-1:0][DataWidth-1:0] sourceData;
        logic [IndexWidth-1:0]                 sourceIndex;
        logic                                  sourceValid;

        // General registers sit at the low indices, MDR at the top
        assign sourceSel  = {mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, regOut};
        assign sourceData = {mdrData, pcData, zLow, zHigh, loData, hiData, regData};

        always_comb begin
                sourceIndex = '0;
                sourceValid = 1'b0;
                for (int i = 0; i < SourceCount; i++) begin
                        if (sourceSel[i]) begin
                                sourceIndex = IndexWidth'(i);
                                sourceValid = 1'b1;
                        end
                end
        end

        // With no strobe raised the bus floats to zero
        assign bus = sourceValid ? sourceData[sourceIndex] : '0;

        // Two drivers at once would be a sequencer fault, the real bus would contend
        assert property (@(posedge Clock) disable iff (!arstN) $onehot0(sourceSel))
                else $error("busMux: more than one out strobe high: %b", sourceSel);

endmodule

`default_nettype wire

//--- design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile #(
        parameter int DataWidth = 32
) (
        input  wire logic                                 Clock,
        input  wire logic                                 arstN,
        input  wire logic [DataWidth-1:0]                 bus,
        input  wire logic [datapathPkg::RegCount-1:0]     regIn,
        input  wire logic                                 hiIn,
        input  wire logic                                 loIn,
        output logic [datapathPkg::RegCount-1:0][DataWidth-1:0] regData,
        output logic [DataWidth-1:0]                      hiData,
        output logic [DataWidth-1:0]                      loData
);

        import datapathPkg::*;

        // Each general register takes the bus when its own in bit is high
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        regData <= '0;
                end else begin
                        for (int i = 0; i < RegCount; i++) begin
                                if (regIn[i]) begin
                                        regData[i] <= bus;
                                end
                        end
                end
        end

        // HI and LO normally receive the two halves of Z after mul or div
        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        hiData <= '0;
                end else if (hiIn) begin
                        hiData <= bus;
                end
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        loData <= '0;
                end else if (loIn) begin
                        loData <= bus;
                end
        end

endmodule

`default_nettype wire

//--- design/datapathPkg.sv
`default_nettype none

package datapathPkg;

        // ALU operation codes as the sequencer drives them on opcode
        typedef enum logic [4:0] {
                Add = 5'b00011,
                Sub = 5'b00100,
                And = 5'b00101,
                Or  = 5'b00110,
                Shr = 5'b00111,
                Shl = 5'b01000,
                Ror = 5'b01001,
                Rol = 5'b01010,
                Mul = 5'b01111,
                Div = 5'b10000,
                Neg = 5'b10001,
                Not = 5'b10010
        } aluOp_t;

        // Number of general registers R0 to R15
        localparam int RegCount = 16;

        // Sources that can drive the bus
        // The general registers, then HI, LO, Z high, Z low, PC and MDR
        localparam int SourceCount = RegCount + 6;

endpackage

`default_nettype wire
